// File: include/filter_consts.svh
`ifndef FILTER_CONSTS_SVH
`define FILTER_CONSTS_SVH

// Bits in one duty or phase value.
`define FILTER_WIDTH 9

// Transducers served per frame.
`define FILTER_DEPTH 249

// Register stages inside addsub.
`define ADDSUB_LATENCY 2

`endif

// File: logic/filter_pkg.sv
`include "filter_consts.svh"

package filter_pkg;

  // Duty command for one transducer.
  typedef logic [`FILTER_WIDTH-1:0] duty_t;

  // Phase on a cycle of 2**FILTER_WIDTH steps.
  typedef logic [`FILTER_WIDTH-1:0] phase_t;

  // Calibration offset, one bit wider than the data to span both signs.
  typedef logic signed [`FILTER_WIDTH:0] offset_t;

  // Room for data plus offset without overflow.
  typedef logic signed [`FILTER_WIDTH+1:0] sum_t;

  // Index into the transducer array.
  typedef logic [$clog2(`FILTER_DEPTH)-1:0] trans_idx_t;

  // Frame sequencer states.
  typedef enum logic {
    waiting, // Idle, looking for a start strobe.
    run      // Frame in flight.
  } filter_state_t;

endpackage

// File: logic/offset_rd_if.sv
`timescale 1ns/10ps

// Read port of the offset table; data follows rd_en by one cycle.
interface offset_rd_if;

  logic                   rd_en;
  filter_pkg::trans_idx_t addr;
  filter_pkg::offset_t    duty_ofs;  // Held until the next read.
  filter_pkg::offset_t    phase_ofs;

  // Table side.
  modport tbl (
    input  rd_en,
    input  addr,
    output duty_ofs,
    output phase_ofs
  );

  modport filter (
    output rd_en,
    output addr,
    input  duty_ofs,
    input  phase_ofs
  );

endinterface

// File: logic/addsub.sv
`timescale 1ns/10ps

module addsub
  import filter_pkg::*;
(
  input  logic CLK,
  input  sum_t a,
  input  sum_t b,
  input  bit   add,
  output sum_t s
);

  sum_t a_r;
  sum_t b_r;
  bit   add_r;

  always_ff @(posedge CLK) begin
    a_r   <= a; // Operand stage.
    b_r   <= b;
    add_r <= add;
    if (add_r) begin
      s <= a_r + b_r; // Result stage.
    end else begin
      s <= a_r - b_r;
    end
  end

endmodule

// File: logic/offset_table.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

module offset_table
  import filter_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  logic       we,
  input  trans_idx_t waddr,
  input  offset_t    wduty,
  input  offset_t    wphase,
  offset_rd_if.tbl   rd
);

  localparam trans_idx_t LAST_IDX = trans_idx_t'(`FILTER_DEPTH - 1);

  offset_t    duty_mem[`FILTER_DEPTH];
  offset_t    phase_mem[`FILTER_DEPTH];
  trans_idx_t clr_cnt;
  logic       clr_busy;

  // Walks every entry once after reset.
  always_ff @(posedge CLK) begin
    if (reset) begin
      clr_busy <= 1'b1;
      clr_cnt  <= '0;
    end else if (clr_busy) begin
      if (clr_cnt == LAST_IDX) begin
        clr_busy <= 1'b0;
      end
      clr_cnt <= clr_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (clr_busy) begin
      duty_mem[clr_cnt]  <= '0; // Host writes wait for the clear.
      phase_mem[clr_cnt] <= '0;
    end else if (we) begin
      duty_mem[waddr]  <= wduty;
      phase_mem[waddr] <= wphase;
    end
    if (rd.rd_en) begin
      rd.duty_ofs  <= duty_mem[rd.addr]; // Old data on a same-edge write.
      rd.phase_ofs <= phase_mem[rd.addr];
    end
  end

endmodule

// File: logic/drive_filter.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

module drive_filter
  import filter_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        din_valid,
  input  duty_t       duty,
  input  phase_t      phase,
  offset_rd_if.filter ofs,
  output duty_t       duty_f,
  output phase_t      phase_f,
  output trans_idx_t  dout_idx,
  output logic        dout_valid
);

  localparam int LAT = `ADDSUB_LATENCY;
  localparam duty_t DUTY_MAX = duty_t'((1 << `FILTER_WIDTH) - 1);
  localparam sum_t PERIOD = sum_t'(1 << `FILTER_WIDTH);
  localparam trans_idx_t LAST_IDX = trans_idx_t'(`FILTER_DEPTH - 1);

  filter_state_t state;

  duty_t      duty_r;
  duty_t      duty_d;
  phase_t     phase_r;
  phase_t     phase_d;
  logic       rd_en;
  trans_idx_t rd_addr;
  logic [LAT:0]   add_vld;  // Offsets ready, then the add pipeline.
  logic [LAT-1:0] fold_vld;
  trans_idx_t fold_cnt;
  duty_t      duty_dly[LAT];
  trans_idx_t idx_dly[LAT];

  sum_t a_duty;
  sum_t b_duty;
  sum_t s_duty;
  sum_t a_phase;
  sum_t b_phase;
  sum_t s_phase;
  sum_t a_fold;
  sum_t b_fold;
  sum_t s_fold;
  bit   add_fold;

  assign ofs.rd_en = rd_en;
  assign ofs.addr  = rd_addr;

  // Inputs are two stages old when their offsets arrive.
  assign a_duty  = {2'b00, duty_d};
  assign b_duty  = {ofs.duty_ofs[`FILTER_WIDTH], ofs.duty_ofs};
  assign a_phase = {2'b00, phase_d};
  assign b_phase = {ofs.phase_ofs[`FILTER_WIDTH], ofs.phase_ofs};

  addsub duty_add_i (
    .CLK (CLK),
    .a   (a_duty),
    .b   (b_duty),
    .add (1'b1),
    .s   (s_duty)
  );

  addsub phase_add_i (
    .CLK (CLK),
    .a   (a_phase),
    .b   (b_phase),
    .add (1'b1),
    .s   (s_phase)
  );

  addsub phase_fold_i (
    .CLK (CLK),
    .a   (a_fold),
    .b   (b_fold),
    .add (add_fold),
    .s   (s_fold)
  );

  assign phase_f = s_fold[`FILTER_WIDTH-1:0]; // Folded result is already in range.

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= waiting;
      rd_en    <= 1'b0;
      rd_addr  <= '0;
      fold_cnt <= '0;
    end else begin
      case (state)
        waiting: begin
          if (din_valid) begin
            state    <= run;
            rd_en    <= 1'b1;
            rd_addr  <= '0;
            fold_cnt <= '0;
          end
        end
        run: begin
          if (rd_en) begin
            if (rd_addr == LAST_IDX) begin
              rd_en <= 1'b0;
            end else begin
              rd_addr <= rd_addr + 1'b1;
            end
          end
          if (add_vld[LAT]) begin
            fold_cnt <= fold_cnt + 1'b1;
          end
          if (dout_valid && dout_idx == LAST_IDX) begin
            state <= waiting; // Frame ends with its last output.
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      add_vld    <= '0;
      fold_vld   <= '0;
      dout_valid <= 1'b0;
    end else begin
      add_vld    <= {add_vld[LAT-1:0], rd_en};
      fold_vld   <= {fold_vld[LAT-2:0], add_vld[LAT]};
      dout_valid <= fold_vld[LAT-1];
    end
  end

  always_ff @(posedge CLK) begin
    duty_r  <= duty;
    phase_r <= phase;
    duty_d  <= duty_r;  // Waits out the table read.
    phase_d <= phase_r;

    if (s_duty > sum_t'(DUTY_MAX)) begin
      duty_dly[0] <= DUTY_MAX;
    end else if (s_duty[`FILTER_WIDTH+1]) begin
      duty_dly[0] <= '0;
    end else begin
      duty_dly[0] <= s_duty[`FILTER_WIDTH-1:0];
    end

    // Pick the fold correction for the phase sum.
    a_fold <= s_phase;
    if (s_phase >= PERIOD) begin
      b_fold   <= PERIOD;
      add_fold <= 1'b0;
    end else if (s_phase[`FILTER_WIDTH+1]) begin
      b_fold   <= PERIOD;
      add_fold <= 1'b1;
    end else begin
      b_fold   <= '0;
      add_fold <= 1'b1;
    end

    idx_dly[0] <= fold_cnt;
    for (int i = 1; i < LAT; i++) begin
      duty_dly[i] <= duty_dly[i-1]; // Match the fold adder.
      idx_dly[i]  <= idx_dly[i-1];
    end
    duty_f   <= duty_dly[LAT-1];
    dout_idx <= idx_dly[LAT-1];
  end

endmodule

// File: logic/drive_filter_top.sv
`timescale 1ns/10ps

module drive_filter_top
  import filter_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  logic       ofs_we,
  input  trans_idx_t ofs_addr,
  input  offset_t    ofs_duty,
  input  offset_t    ofs_phase,
  input  logic       din_valid,
  input  duty_t      duty,
  input  phase_t     phase,
  output duty_t      duty_f,
  output phase_t     phase_f,
  output trans_idx_t dout_idx,
  output logic       dout_valid
);

  offset_rd_if ofs_rd (); // Filter reads calibration here.

  offset_table offset_table_i (
    .CLK    (CLK),
    .reset  (reset),
    .we     (ofs_we),
    .waddr  (ofs_addr),
    .wduty  (ofs_duty),
    .wphase (ofs_phase),
    .rd     (ofs_rd.tbl)
  );

  drive_filter drive_filter_i (
    .CLK        (CLK),
    .reset      (reset),
    .din_valid  (din_valid),
    .duty       (duty),
    .phase      (phase),
    .ofs        (ofs_rd.filter),
    .duty_f     (duty_f),
    .phase_f    (phase_f),
    .dout_idx   (dout_idx),
    .dout_valid (dout_valid)
  );

endmodule

// File: dv/drive_filter_props.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

module drive_filter_props
  import filter_pkg::*;
(
  input logic       CLK,
  input logic       reset,
  input logic       dout_valid,
  input trans_idx_t dout_idx
);

  int unsigned run_len; // Valid cycles so far in this run.
  int unsigned fail_reset = 0;
  int unsigned fail_run = 0;
  int unsigned fail_idx = 0;

  always_ff @(posedge CLK) begin
    if (reset) begin
      run_len <= 0;
    end else if (dout_valid) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  reset_low: assert property (@(posedge CLK) reset |=> !dout_valid)
    else begin
      fail_reset++;
      $error("dout_valid high after a reset edge");
    end

  // A run ends exactly at the frame length.
  run_full: assert property (@(posedge CLK) disable iff (reset)
    $fell(dout_valid) |-> run_len == `FILTER_DEPTH)
    else begin
      fail_run++;
      $error("dout_valid run length is not the transducer count");
    end

  idx_step: assert property (@(posedge CLK) disable iff (reset)
    dout_valid && $past(dout_valid) |-> dout_idx == $past(dout_idx) + 1'b1)
    else begin
      fail_idx++;
      $error("dout_idx did not advance by one");
    end

endmodule

bind drive_filter drive_filter_props drive_filter_props_i (
  .CLK        (CLK),
  .reset      (reset),
  .dout_valid (dout_valid),
  .dout_idx   (dout_idx)
);

// File: dv/drive_filter_tb.sv
`timescale 1ns/10ps
`include "filter_consts.svh"

module drive_filter_tb
  import filter_pkg::*;
();

  localparam int DEPTH = `FILTER_DEPTH;
  localparam int MAXV = (1 << `FILTER_WIDTH) - 1;
  localparam int NUM_TESTS = 6;
  localparam int MID_K = 100; // Stray start strobe inside a frame.
  localparam int LIMIT = NUM_TESTS * (DEPTH * 2 + 300) + 300;

  typedef enum logic [1:0] {OFS_ZERO, OFS_RANDOM, OFS_POS, OFS_NEG} ofs_mode_t;
  typedef enum logic [1:0] {IN_RANDOM, IN_MAX, IN_MIN} in_mode_t;
  typedef struct packed {
    ofs_mode_t ofs_mode;
    in_mode_t  in_mode;
    logic      b2b;      // Second frame right after the first.
  } test_row_t;

  logic       CLK = 1'b0;
  logic       reset;
  logic       ofs_we;
  trans_idx_t ofs_addr;
  offset_t    ofs_duty;
  offset_t    ofs_phase;
  logic       din_valid;
  duty_t      duty;
  phase_t     phase;
  duty_t      duty_f;
  phase_t     phase_f;
  trans_idx_t dout_idx;
  logic       dout_valid;

  test_row_t   tests[NUM_TESTS];
  logic [31:0] lfsr = 32'h3459;
  int          duty_ofs_tab[DEPTH];
  int          phase_ofs_tab[DEPTH];
  int          in_duty[2][DEPTH];
  int          in_phase[2][DEPTH];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          asrt_fails;

  drive_filter_top drive_filter_top_i (.*);

  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit.
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic int offset_value(input ofs_mode_t mode);
    case (mode)
      OFS_RANDOM: return rand_bits(10) - 512; // Full signed range.
      OFS_POS:    return 256 + rand_bits(8);
      OFS_NEG:    return -256 - rand_bits(8);
      default:    return 0;
    endcase
  endfunction

  function automatic int input_value(input in_mode_t mode);
    case (mode)
      IN_MAX:  return MAXV;
      IN_MIN:  return 0;
      default: return rand_bits(`FILTER_WIDTH);
    endcase
  endfunction

  // Saturate duty into the legal range.
  function automatic int model_duty(input int d, input int o);
    int s;
    s = d + o;
    return (s > MAXV) ? MAXV : ((s < 0) ? 0 : s);
  endfunction

  function automatic int model_phase(input int p, input int o);
    return (p + o + 2 * (MAXV + 1)) % (MAXV + 1); // Wraps on the phase cycle.
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic write_offsets(input ofs_mode_t mode);
    for (int i = 0; i < DEPTH; i++) begin
      duty_ofs_tab[i]  = offset_value(mode);
      phase_ofs_tab[i] = offset_value(mode);
      @(posedge CLK);
      check("dout_valid", 32'(dout_valid), 32'h0);
      ofs_we    <= 1'b1;
      ofs_addr  <= trans_idx_t'(i);
      ofs_duty  <= offset_t'(duty_ofs_tab[i]);
      ofs_phase <= offset_t'(phase_ofs_tab[i]);
    end
    @(posedge CLK);
    ofs_we <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int nframes;
    int drv_f;
    int drv_k;
    int mon_f;
    int mon_n;
    int outs;
    int idle;
    int idx;
    int err0;
    err0 = errors;
    nframes = tests[t].b2b ? 2 : 1;
    write_offsets(tests[t].ofs_mode);
    for (int f = 0; f < nframes; f++) begin
      for (int k = 0; k < DEPTH; k++) begin
        in_duty[f][k]  = input_value(tests[t].in_mode);
        in_phase[f][k] = input_value(tests[t].in_mode);
      end
    end
    drv_f = 0;
    drv_k = 0;
    mon_f = 0;
    mon_n = 0;
    outs = 0;
    idle = 0;
    while (mon_f < nframes || idle < 20) begin
      @(posedge CLK);
      if (dout_valid) begin
        idx = int'(dout_idx);
        outs++;
        if (mon_f >= nframes || idx >= DEPTH) begin
          errors++;
          $display("Unexpected output at %0d ns: index %0d lies outside the expected frames",
                   $time, idx);
        end else begin
          check("dout_idx", 32'(dout_idx), 32'(mon_n));
          check("duty_f", 32'(duty_f),
                32'(model_duty(in_duty[mon_f][idx], duty_ofs_tab[idx])));
          check("phase_f", 32'(phase_f),
                32'(model_phase(in_phase[mon_f][idx], phase_ofs_tab[idx])));
          mon_n++;
          if (mon_n == DEPTH) begin
            mon_f++;
            mon_n = 0;
          end
        end
      end else if (mon_f == nframes) begin
        idle++;
      end
      if (drv_k == DEPTH && drv_f + 1 < nframes && mon_f > drv_f) begin
        drv_f++; // Next frame right after the last output.
        drv_k = 0;
      end
      if (drv_k < DEPTH) begin
        din_valid <= (drv_k == 0 || drv_k == MID_K);
        duty      <= duty_t'(in_duty[drv_f][drv_k]);
        phase     <= phase_t'(in_phase[drv_f][drv_k]);
        drv_k++;
      end else begin
        din_valid <= 1'b0;
      end
    end
    check("output count", 32'(outs), 32'(nframes * DEPTH));
    $display("Test %0d done: %0d frame(s), %0d outputs, %0d errors",
             t, nframes, outs, errors - err0);
  endtask

  initial begin
    reset     = 1'b1;
    ofs_we    = 1'b0;
    ofs_addr  = '0;
    ofs_duty  = '0;
    ofs_phase = '0;
    din_valid = 1'b0;
    duty      = '0;
    phase     = '0;
    tests[0] = '{OFS_ZERO, IN_RANDOM, 1'b0};
    tests[1] = '{OFS_RANDOM, IN_RANDOM, 1'b0};
    tests[2] = '{OFS_POS, IN_MAX, 1'b0};
    tests[3] = '{OFS_NEG, IN_MIN, 1'b0};
    tests[4] = '{OFS_RANDOM, IN_RANDOM, 1'b1};
    tests[5] = '{OFS_POS, IN_RANDOM, 1'b1};
    repeat (16) @(posedge CLK);
    reset <= 1'b0;
    repeat (DEPTH) begin
      @(posedge CLK);
      check("dout_valid", 32'(dout_valid), 32'h0); // Table clear period.
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    asrt_fails = drive_filter_top_i.drive_filter_i.drive_filter_props_i.fail_reset
               + drive_filter_top_i.drive_filter_i.drive_filter_props_i.fail_run
               + drive_filter_top_i.drive_filter_i.drive_filter_props_i.fail_idx;
    $display("Summary: %0d tests, %0d checks, %0d check errors, %0d assertion failures",
             NUM_TESTS, checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
logic/filter_pkg.sv
logic/offset_rd_if.sv
logic/addsub.sv
logic/offset_table.sv
logic/drive_filter.sv
logic/drive_filter_top.sv
dv/drive_filter_props.sv
dv/drive_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f \
  --top-module drive_filter_tb -o drive_filter_sim &&
  ./obj_dir/drive_filter_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
